// File: hw/vtp_pkg.sv
package vtp_pkg;

    // ======================================================================
    // Address geometry
    // ======================================================================

    // Requests carry the byte address of a cache line
    localparam int ADDR_W = 32;

    // A 4 KB page splits the word into a page number and a 12-bit offset
    localparam int PAGE4K_W = 20;
    localparam int OFF4K_W = ADDR_W - PAGE4K_W;

    // A 2 MB page keeps only the top 11 bits as page number
    localparam int PAGE2M_W = 11;
    localparam int OFF2M_W = ADDR_W - PAGE2M_W;

    // Tag is opaque to the design and travels untouched
    localparam int TAG_W = 8;
    localparam int DATA_W = 32;

    // Pipe stage that taps the TLB and the stage where the decision is made
    // The TLB delays its answer by the difference so both meet at the end
    localparam int LOOKUP_STAGE = 1;
    localparam int PIPE_LAST_STAGE = 5;

    // ======================================================================
    // Request and TLB types
    // ======================================================================

    typedef enum logic [1:0]
    {
        KIND_READ  = 2'd0,
        KIND_WRITE = 2'd1,
        KIND_FENCE = 2'd2
    } vtp_kind_t;

    typedef struct packed
    {
        logic [PAGE4K_W-1:0] page;
        logic [OFF4K_W-1:0]  offset;
    } vtp_addr4k_t;

    typedef struct packed
    {
        logic [PAGE2M_W-1:0] page;
        logic [OFF2M_W-1:0]  offset;
    } vtp_addr2m_t;

    // One address word, read either as a 4 KB or as a 2 MB page split
    typedef union packed
    {
        vtp_addr4k_t page4k;
        vtp_addr2m_t page2m;
    } vtp_addr_u;

    typedef struct packed
    {
        logic              valid;
        vtp_kind_t         kind;
        logic              addr_is_virtual;
        vtp_addr_u         addr;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data;
    } vtp_req_t;

    // Answer to one channel, valid means a hit
    typedef struct packed
    {
        logic                valid;
        logic [PAGE4K_W-1:0] pa_page;
        logic                big;
    } vtp_lookup_t;

    // For a big mapping only the top PAGE2M_W bits of both pages count
    typedef struct packed
    {
        logic                valid;
        logic [PAGE4K_W-1:0] va_page;
        logic [PAGE4K_W-1:0] pa_page;
        logic                big;
    } vtp_fill_t;

endpackage

// File: hw/vtp_tlb.sv
module vtp_tlb
#(
    parameter int NUM_CHANNELS = 2,
    parameter int TLB_ENTRIES = 8
)
(
    input  logic                          clk,
    input  logic                          reset,
    input  vtp_pkg::vtp_fill_t            fill,
    input  logic [NUM_CHANNELS-1:0]       lookup_en,
    input  logic [vtp_pkg::PAGE4K_W-1:0]  lookup_page [NUM_CHANNELS],
    output vtp_pkg::vtp_lookup_t          lookup_rsp [NUM_CHANNELS]
);
    import vtp_pkg::*;

    // Answer must reach the request when it sits in the last pipe stage
    localparam int DELAY = PIPE_LAST_STAGE - LOOKUP_STAGE;
    localparam int IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

    logic [TLB_ENTRIES-1:0] ent_valid;
    logic [TLB_ENTRIES-1:0] ent_big;
    logic [PAGE4K_W-1:0]    ent_va [TLB_ENTRIES];
    logic [PAGE4K_W-1:0]    ent_pa [TLB_ENTRIES];
    logic [IDX_W-1:0]       fill_ptr;
    logic [IDX_W-1:0]       fill_idx;
    logic                   fill_hit;
    vtp_lookup_t            lookup_now [NUM_CHANNELS];
    vtp_lookup_t            rsp_dly [NUM_CHANNELS][DELAY];

    // A big entry only compares the 2 MB page bits
    function automatic logic page_match(input logic [PAGE4K_W-1:0] ent,
                                        input logic [PAGE4K_W-1:0] req,
                                        input logic big);
        if (big)
            return ent[PAGE4K_W-1 -: PAGE2M_W] == req[PAGE4K_W-1 -: PAGE2M_W];
        return ent == req;
    endfunction

    // ======================================================================
    // Fill port
    // ======================================================================

    // A fill for a page already held reuses that slot, otherwise the
    // round-robin pointer picks the victim
    always_comb
    begin
        fill_hit = 1'b0;
        fill_idx = fill_ptr;
        for (int e = 0; e < TLB_ENTRIES; e++)
        begin
            if (!fill_hit && ent_valid[e] && (ent_va[e] == fill.va_page))
            begin
                fill_hit = 1'b1;
                fill_idx = IDX_W'(e);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill.valid)
        begin
            ent_va[fill_idx] <= fill.va_page;
            ent_pa[fill_idx] <= fill.pa_page;
            ent_big[fill_idx] <= fill.big;
        end

        if (reset)
        begin
            ent_valid <= '0;
            fill_ptr <= '0;
        end
        else if (fill.valid)
        begin
            ent_valid[fill_idx] <= 1'b1;
            // The pointer only moves when a fresh slot was consumed
            if (!fill_hit)
                fill_ptr <= (fill_ptr == IDX_W'(TLB_ENTRIES - 1)) ? '0 : fill_ptr + 1'b1;
        end
    end

    // ======================================================================
    // Lookup ports
    // ======================================================================

    // Every channel searches all entries in parallel, first hit wins
    always_comb
    begin
        for (int c = 0; c < NUM_CHANNELS; c++)
        begin
            lookup_now[c] = '0;
            for (int e = 0; e < TLB_ENTRIES; e++)
            begin
                if (lookup_en[c] && ent_valid[e] && !lookup_now[c].valid &&
                    page_match(ent_va[e], lookup_page[c], ent_big[e]))
                begin
                    lookup_now[c].valid = 1'b1;
                    lookup_now[c].pa_page = ent_pa[e];
                    lookup_now[c].big = ent_big[e];
                end
            end
        end
    end

    // Delay line per channel lines the answer up with the last stage
    always_ff @(posedge clk)
    begin
        for (int c = 0; c < NUM_CHANNELS; c++)
        begin
            rsp_dly[c][0] <= lookup_now[c];
            for (int d = 1; d < DELAY; d++)
                rsp_dly[c][d] <= rsp_dly[c][d-1];
        end

        if (reset)
        begin
            for (int c = 0; c < NUM_CHANNELS; c++)
                for (int d = 0; d < DELAY; d++)
                    rsp_dly[c][d].valid <= 1'b0;
        end
    end

    always_comb
    begin
        for (int c = 0; c < NUM_CHANNELS; c++)
            lookup_rsp[c] = rsp_dly[c][DELAY-1];
    end

endmodule

// File: hw/vtp_channel_pipe.sv
module vtp_channel_pipe
(
    input  logic                          clk,
    input  logic                          reset,
    input  vtp_pkg::vtp_req_t             in_req,
    output logic                          accept,
    output logic                          lookup_en,
    output logic [vtp_pkg::PAGE4K_W-1:0]  lookup_page,
    input  vtp_pkg::vtp_lookup_t          lookup_rsp,
    output vtp_pkg::vtp_req_t             pipe_out,
    input  logic                          almost_full
);
    import vtp_pkg::*;

    // Stage 0 holds the newest entry, PIPE_LAST_STAGE the oldest
    vtp_req_t stage [PIPE_LAST_STAGE+1];
    vtp_req_t in_take;
    vtp_req_t last;
    vtp_req_t out_next;

    logic ready_q;
    logic almost_full_q;
    logic wr_accepted_q;
    logic last_needs_xlate;
    logic can_fwd;
    logic fwd_req;
    logic retry_req;
    logic pipe_busy;
    logic block_fence;

    // ======================================================================
    // Forward or retry decision at the last stage
    // ======================================================================

    assign last = stage[PIPE_LAST_STAGE];

    // Fences carry no address worth translating
    assign last_needs_xlate = last.addr_is_virtual && (last.kind != KIND_FENCE);

    // The arbiter level is registered once, the queue leaves room for that
    assign can_fwd = (lookup_rsp.valid || !last_needs_xlate) && !almost_full_q;
    assign fwd_req = last.valid && can_fwd;

    // A miss or back-pressure sends the oldest request round again
    assign retry_req = last.valid && !can_fwd;

    // ======================================================================
    // Input side and fence blocking
    // ======================================================================

    // Since the pipe reorders freely, a fence may only enter once every
    // older request of this channel has moved past the last stage
    always_comb
    begin
        pipe_busy = wr_accepted_q;
        for (int s = 0; s <= PIPE_LAST_STAGE; s++)
            pipe_busy = pipe_busy || stage[s].valid;
    end

    assign block_fence = in_req.valid && (in_req.kind == KIND_FENCE) && pipe_busy;

    // Retries own stage 1 this cycle, so nothing new can enter
    assign accept = ready_q && !retry_req && !block_fence;

    always_comb
    begin
        in_take = in_req;
        in_take.valid = in_req.valid && accept;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ready_q <= 1'b0;
            almost_full_q <= 1'b0;
            wr_accepted_q <= 1'b0;
        end
        else
        begin
            ready_q <= 1'b1;
            almost_full_q <= almost_full;
            wr_accepted_q <= in_take.valid && (in_req.kind == KIND_WRITE);
        end
    end

    // ======================================================================
    // Pipe advance
    // ======================================================================

    always_ff @(posedge clk)
    begin
        // Stages past the retry point are a plain shift register
        for (int s = 1; s < PIPE_LAST_STAGE; s++)
            stage[s+1] <= stage[s];

        // Stage 0 holds its entry while a retry takes stage 1
        if (!retry_req)
            stage[0] <= in_take;

        stage[1] <= retry_req ? last : stage[0];

        if (reset)
        begin
            for (int s = 0; s <= PIPE_LAST_STAGE; s++)
                stage[s].valid <= 1'b0;
        end
    end

    // TLB tap, only virtual reads and writes ask for a translation
    assign lookup_page = stage[LOOKUP_STAGE].addr.page4k.page;
    assign lookup_en = stage[LOOKUP_STAGE].valid &&
                       stage[LOOKUP_STAGE].addr_is_virtual &&
                       (stage[LOOKUP_STAGE].kind != KIND_FENCE);

    // ======================================================================
    // Address rewrite
    // ======================================================================

    // The offset bits overlap in both union views, so only the page field
    // gets replaced and the offset is kept as it is
    always_comb
    begin
        out_next = last;
        out_next.valid = fwd_req;
        if (last_needs_xlate)
        begin
            if (lookup_rsp.big)
                out_next.addr.page2m.page = lookup_rsp.pa_page[PAGE4K_W-1 -: PAGE2M_W];
            else
                out_next.addr.page4k.page = lookup_rsp.pa_page;
            out_next.addr_is_virtual = 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        pipe_out <= out_next;
        if (reset)
            pipe_out.valid <= 1'b0;
    end

endmodule

// File: hw/vtp_out_arbiter.sv
module vtp_out_arbiter
#(
    parameter int NUM_CHANNELS = 2
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  vtp_pkg::vtp_req_t        pipe_out [NUM_CHANNELS],
    output logic [NUM_CHANNELS-1:0]  almost_full,
    output vtp_pkg::vtp_req_t        out_req,
    input  logic                     out_almost_full
);
    import vtp_pkg::*;

    // Two entries in flight behind the registered level need the spare room
    localparam int Q_DEPTH = 4;
    localparam int PTR_W = 2;
    localparam int AF_LEVEL = 2;
    localparam int CH_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

    vtp_req_t          q_mem [NUM_CHANNELS][Q_DEPTH];
    logic [PTR_W-1:0]  rd_ptr [NUM_CHANNELS];
    logic [PTR_W-1:0]  wr_ptr [NUM_CHANNELS];
    logic [PTR_W:0]    count [NUM_CHANNELS];
    logic [CH_W-1:0]   rr_last;
    logic [CH_W-1:0]   grant;
    logic              grant_valid;
    int                idx;

    always_comb
    begin
        for (int c = 0; c < NUM_CHANNELS; c++)
            almost_full[c] = count[c] >= (PTR_W+1)'(AF_LEVEL);
    end

    // Search starts just past the last channel served
    always_comb
    begin
        grant_valid = 1'b0;
        grant = rr_last;
        idx = 0;
        for (int k = 1; k <= NUM_CHANNELS; k++)
        begin
            idx = (int'(rr_last) + k) % NUM_CHANNELS;
            if (!grant_valid && !out_almost_full && (count[idx] != '0))
            begin
                grant_valid = 1'b1;
                grant = CH_W'(idx);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        for (int c = 0; c < NUM_CHANNELS; c++)
        begin
            if (pipe_out[c].valid)
                q_mem[c][wr_ptr[c]] <= pipe_out[c];
        end
        out_req <= q_mem[grant][rd_ptr[grant]];
        out_req.valid <= grant_valid;

        if (reset)
        begin
            out_req.valid <= 1'b0;
            rr_last <= '0;
            for (int c = 0; c < NUM_CHANNELS; c++)
            begin
                rd_ptr[c] <= '0;
                wr_ptr[c] <= '0;
                count[c] <= '0;
            end
        end
        else
        begin
            if (grant_valid)
                rr_last <= grant;
            for (int c = 0; c < NUM_CHANNELS; c++)
            begin
                if (pipe_out[c].valid)
                    wr_ptr[c] <= wr_ptr[c] + 1'b1;
                if (grant_valid && (grant == CH_W'(c)))
                    rd_ptr[c] <= rd_ptr[c] + 1'b1;
                count[c] <= count[c] + (PTR_W+1)'(pipe_out[c].valid)
                          - (PTR_W+1)'(grant_valid && (grant == CH_W'(c)));
            end
        end
    end

endmodule

// File: hw/vtp_translate_top.sv
module vtp_translate_top
#(
    parameter int NUM_CHANNELS = 2,
    parameter int TLB_ENTRIES = 8
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  vtp_pkg::vtp_req_t        in_req [NUM_CHANNELS],
    output logic [NUM_CHANNELS-1:0]  accept,
    input  vtp_pkg::vtp_fill_t       fill,
    output vtp_pkg::vtp_req_t        out_req,
    input  logic                     out_almost_full
);
    import vtp_pkg::*;

    logic [NUM_CHANNELS-1:0] lookup_en;
    logic [PAGE4K_W-1:0]     lookup_page [NUM_CHANNELS];
    vtp_lookup_t             lookup_rsp [NUM_CHANNELS];
    vtp_req_t                pipe_out [NUM_CHANNELS];
    logic [NUM_CHANNELS-1:0] almost_full;

    // One TLB shared by all channels, one lookup port each
    vtp_tlb
    #(
        .NUM_CHANNELS (NUM_CHANNELS),
        .TLB_ENTRIES  (TLB_ENTRIES)
    )
    u_tlb
    (
        .clk         (clk),
        .reset       (reset),
        .fill        (fill),
        .lookup_en   (lookup_en),
        .lookup_page (lookup_page),
        .lookup_rsp  (lookup_rsp)
    );

    for (genvar i = 0; i < NUM_CHANNELS; i++)
    begin : g_chan
        vtp_channel_pipe u_pipe
        (
            .clk         (clk),
            .reset       (reset),
            .in_req      (in_req[i]),
            .accept      (accept[i]),
            .lookup_en   (lookup_en[i]),
            .lookup_page (lookup_page[i]),
            .lookup_rsp  (lookup_rsp[i]),
            .pipe_out    (pipe_out[i]),
            .almost_full (almost_full[i])
        );
    end

    // Merges all channels onto the single outgoing port
    vtp_out_arbiter
    #(
        .NUM_CHANNELS (NUM_CHANNELS)
    )
    u_arbiter
    (
        .clk             (clk),
        .reset           (reset),
        .pipe_out        (pipe_out),
        .almost_full     (almost_full),
        .out_req         (out_req),
        .out_almost_full (out_almost_full)
    );

endmodule

// File: tb/vtp_translate_properties.sv
module vtp_translate_properties
#(
    parameter int NUM_CHANNELS = 2
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic [NUM_CHANNELS-1:0]  accept,
    input  vtp_pkg::vtp_req_t        out_req,
    input  logic                     out_almost_full
);

    // ======================================================================
    // Outgoing port rules
    // ======================================================================

    // Translation is finished before anything reaches the outgoing port
    a_out_physical: assert property (@(posedge clk) disable iff (reset)
        out_req.valid |-> !out_req.addr_is_virtual)
        else $error("out_req left with addr_is_virtual set");

    // Once reset has been seen at one edge, the DUT stays quiet until it drops
    a_quiet_in_reset: assert property (@(posedge clk)
        (reset && $past(reset)) |-> ((accept == '0) && !out_req.valid))
        else $error("accept or out_req.valid high during reset");

    // The outside's level stops new requests from the next edge on
    a_backpressure: assert property (@(posedge clk) disable iff (reset)
        $past(out_almost_full) |-> !out_req.valid)
        else $error("out_req.valid one cycle after out_almost_full was high");

endmodule

bind vtp_translate_top vtp_translate_properties
#(
    .NUM_CHANNELS (NUM_CHANNELS)
)
u_props
(
    .clk             (clk),
    .reset           (reset),
    .accept          (accept),
    .out_req         (out_req),
    .out_almost_full (out_almost_full)
);

// File: tb/vtp_translate_checker.sv
module vtp_translate_checker
#(
    parameter int NUM_CHANNELS = 2
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  vtp_pkg::vtp_req_t        in_req [NUM_CHANNELS],
    input  logic [NUM_CHANNELS-1:0]  accept,
    input  vtp_pkg::vtp_fill_t       fill,
    input  vtp_pkg::vtp_req_t        out_req,
    input  logic                     out_almost_full,
    output int                       value_errors,
    output int                       other_errors,
    output int                       outstanding,
    output int                       checked
);
    import vtp_pkg::*;

    localparam int MAP_MAX = 16;
    localparam int NUM_TAGS = 1 << TAG_W;

    // Reference page table, rebuilt from what crosses the fill port
    logic [PAGE4K_W-1:0] map_va [MAP_MAX];
    logic [PAGE4K_W-1:0] map_pa [MAP_MAX];
    logic                map_big [MAP_MAX];
    int                  map_count;

    // Scoreboard of accepted requests, indexed by tag
    vtp_req_t            sent_req [NUM_TAGS];
    int                  seq_of [NUM_TAGS];
    int                  ch_of [NUM_TAGS];
    logic [NUM_TAGS-1:0] pending;
    int                  accept_seq;
    logic                oaf_q;

    // A refill of a known virtual page replaces the old mapping
    task automatic mirror_fill();
        int idx;
        idx = map_count;
        for (int e = 0; e < map_count; e++)
            if (map_va[e] == fill.va_page)
                idx = e;
        if (idx < MAP_MAX)
        begin
            map_va[idx] = fill.va_page;
            map_pa[idx] = fill.pa_page;
            map_big[idx] = fill.big;
            if (idx == map_count)
                map_count++;
        end
    endtask

    // 4 KB keeps 12 offset bits, 2 MB keeps 21 and only the top 11 page bits
    function automatic logic translate(input logic [ADDR_W-1:0] va,
                                       output logic [ADDR_W-1:0] pa);
        logic found;
        found = 1'b0;
        pa = va;
        for (int e = 0; e < map_count; e++)
        begin
            if (!found && map_big[e] &&
                (map_va[e][PAGE4K_W-1 -: PAGE2M_W] == va[ADDR_W-1 -: PAGE2M_W]))
            begin
                found = 1'b1;
                pa = {map_pa[e][PAGE4K_W-1 -: PAGE2M_W], va[OFF2M_W-1:0]};
            end
            else if (!found && !map_big[e] && (map_va[e] == va[ADDR_W-1 -: PAGE4K_W]))
            begin
                found = 1'b1;
                pa = {map_pa[e], va[OFF4K_W-1:0]};
            end
        end
        return found;
    endfunction

    task automatic report_value(input string name, input logic [TAG_W-1:0] tag,
                                input logic [31:0] exp, input logic [31:0] got);
        value_errors++;
        $display("ERROR %0t %s (tag %h) expected %h got %h", $time, name, tag, exp, got);
    endtask

    // ======================================================================
    // Output side
    // ======================================================================

    task automatic check_output();
        logic [TAG_W-1:0]  t;
        vtp_req_t          exp;
        logic [ADDR_W-1:0] exp_addr;
        logic              exp_virt;
        t = out_req.tag;
        if (!pending[t])
        begin
            other_errors++;
            $display("At %0t tag %h left without a matching accepted request", $time, t);
            return;
        end
        exp = sent_req[t];
        exp_addr = exp.addr;
        exp_virt = exp.addr_is_virtual;
        // Fences are never translated, everything else virtual must be
        if (exp.addr_is_virtual && (exp.kind != KIND_FENCE))
        begin
            exp_virt = 1'b0;
            if (!translate(exp.addr, exp_addr))
            begin
                other_errors++;
                $display("At %0t tag %h left although its page is not mapped yet", $time, t);
            end
        end
        if (out_req.addr != exp_addr)
            report_value("out_req.addr", t, exp_addr, out_req.addr);
        if (out_req.kind != exp.kind)
            report_value("out_req.kind", t, 32'(exp.kind), 32'(out_req.kind));
        if (out_req.data != exp.data)
            report_value("out_req.data", t, exp.data, out_req.data);
        if (out_req.addr_is_virtual != exp_virt)
            report_value("out_req.addr_is_virtual", t, 32'(exp_virt),
                         32'(out_req.addr_is_virtual));
        // Everything accepted before the fence on its channel must be gone
        if (exp.kind == KIND_FENCE)
        begin
            for (int u = 0; u < NUM_TAGS; u++)
            begin
                if (pending[u] && (ch_of[u] == ch_of[t]) && (seq_of[u] < seq_of[t]))
                begin
                    other_errors++;
                    $display("At %0t fence %h overtook older request %h", $time, t, u);
                end
            end
        end
        pending[t] = 1'b0;
        outstanding--;
        checked++;
    endtask

    // ======================================================================
    // Input side
    // ======================================================================

    task automatic record_accept(input int c);
        logic [TAG_W-1:0] t;
        t = in_req[c].tag;
        sent_req[t] = in_req[c];
        seq_of[t] = accept_seq;
        ch_of[t] = c;
        pending[t] = 1'b1;
        accept_seq++;
        outstanding++;
    endtask

    always @(posedge clk)
    begin
        if (reset)
        begin
            pending = '0;
            map_count = 0;
            accept_seq = 0;
            value_errors = 0;
            other_errors = 0;
            outstanding = 0;
            checked = 0;
        end
        else
        begin
            if (fill.valid)
                mirror_fill();
            if (out_req.valid && oaf_q)
            begin
                other_errors++;
                $display("At %0t out_req.valid came right after out_almost_full", $time);
            end
            if (out_req.valid)
                check_output();
            for (int c = 0; c < NUM_CHANNELS; c++)
                if (in_req[c].valid && accept[c])
                    record_accept(c);
        end
        oaf_q = out_almost_full;
    end

endmodule

// File: tb/vtp_translate_tb.sv
module vtp_translate_tb;
    import vtp_pkg::*;

    localparam int NUM_CHANNELS = 2;
    localparam int REQS_PER_CH = 48;
    localparam int ACCEPT_LIMIT = 3000;
    localparam int DRAIN_LIMIT = 3000;
    localparam int RUN_LIMIT = 20000;

    logic                    clk = 1'b0;
    logic                    reset;
    vtp_req_t                in_req [NUM_CHANNELS];
    logic [NUM_CHANNELS-1:0] accept;
    vtp_fill_t               fill;
    vtp_req_t                out_req;
    logic                    out_almost_full;
    logic [NUM_CHANNELS-1:0] took;
    logic [31:0]             lfsr = 32'd97238;
    int                      sent [NUM_CHANNELS];
    int                      waited [NUM_CHANNELS];
    int                      cyc;
    int                      fill_at;
    int                      drain_wait;
    int                      timeouts;
    int                      value_errors;
    int                      other_errors;
    int                      outstanding;
    int                      checked;

    always #20 clk = ~clk;

    // Handshake seen at the rising edge, used by the driver at the next falling one
    always @(posedge clk)
    begin
        for (int c = 0; c < NUM_CHANNELS; c++)
            took[c] <= in_req[c].valid && accept[c];
    end

    vtp_translate_top
    #(
        .NUM_CHANNELS (NUM_CHANNELS),
        .TLB_ENTRIES  (8)
    )
    u_dut
    (
        .clk             (clk),
        .reset           (reset),
        .in_req          (in_req),
        .accept          (accept),
        .fill            (fill),
        .out_req         (out_req),
        .out_almost_full (out_almost_full)
    );

    vtp_translate_checker
    #(
        .NUM_CHANNELS (NUM_CHANNELS)
    )
    u_check
    (
        .clk             (clk),
        .reset           (reset),
        .in_req          (in_req),
        .accept          (accept),
        .fill            (fill),
        .out_req         (out_req),
        .out_almost_full (out_almost_full),
        .value_errors    (value_errors),
        .other_errors    (other_errors),
        .outstanding     (outstanding),
        .checked         (checked)
    );

    // Galois LFSR, one step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    // ======================================================================
    // Address map used for stimulus
    // ======================================================================

    // Entries 3 and 4 are 2 MB pages, entry 5 is the page that is filled late
    function automatic vtp_fill_t mapping(input int k);
        vtp_fill_t f;
        f.valid = 1'b1;
        f.big = 1'b0;
        case (k)
            0:       begin f.va_page = 20'h00010; f.pa_page = 20'h80010; end
            1:       begin f.va_page = 20'h00011; f.pa_page = 20'h7ff23; end
            2:       begin f.va_page = 20'h12345; f.pa_page = 20'h00abc; end
            3:       begin f.va_page = 20'h40000; f.pa_page = 20'hc0000; f.big = 1'b1; end
            4:       begin f.va_page = 20'ha0200; f.pa_page = 20'h1fe00; f.big = 1'b1; end
            default: begin f.va_page = 20'h33333; f.pa_page = 20'h55555; end
        endcase
        return f;
    endfunction

    // Picks a page, big pages get random page bits below the 2 MB boundary
    function automatic logic [ADDR_W-1:0] pick_vaddr();
        vtp_fill_t  m;
        logic [2:0] k;
        k = 3'(rand_bits(3));
        if (k > 3'd5)
            k = k - 3'd3;
        m = mapping(int'(k));
        if (m.big)
            return {m.va_page[PAGE4K_W-1 -: PAGE2M_W], OFF2M_W'(rand_bits(OFF2M_W))};
        return {m.va_page, OFF4K_W'(rand_bits(OFF4K_W))};
    endfunction

    function automatic logic stimulus_done();
        logic done;
        done = 1'b1;
        for (int c = 0; c < NUM_CHANNELS; c++)
            if ((sent[c] < REQS_PER_CH) || in_req[c].valid)
                done = 1'b0;
        return done;
    endfunction

    // ======================================================================
    // Driver tasks, all called right after a falling edge
    // ======================================================================

    task automatic step_background();
        cyc++;
        fill = '0;
        if (cyc == fill_at)
            fill = mapping(5);
        if (rand_bits(2) == 32'd0)
            out_almost_full = !out_almost_full;
    endtask

    // Fences go out physical, so only reads and writes are translated
    task automatic new_request(input int c);
        vtp_req_t r;
        r.valid = 1'b1;
        r.tag = TAG_W'(c * 128 + sent[c]);
        r.data = rand_bits(DATA_W);
        r.addr_is_virtual = 1'b0;
        r.addr = rand_bits(ADDR_W);
        if (rand_bits(4) == 32'd0)
            r.kind = KIND_FENCE;
        else
        begin
            r.kind = (rand_bits(1) == 32'd1) ? KIND_WRITE : KIND_READ;
            if (rand_bits(2) != 32'd0)
            begin
                r.addr_is_virtual = 1'b1;
                r.addr = pick_vaddr();
            end
        end
        in_req[c] = r;
        sent[c]++;
        waited[c] = 0;
    endtask

    task automatic drive_channel(input int c);
        if (in_req[c].valid && took[c])
            in_req[c].valid = 1'b0;
        else if (in_req[c].valid)
        begin
            waited[c]++;
            if (waited[c] > ACCEPT_LIMIT)
            begin
                timeouts++;
                $display("Timeout: channel %0d did not accept tag %h", c, in_req[c].tag);
            end
        end
        if (!in_req[c].valid && (sent[c] < REQS_PER_CH) && (rand_bits(1) == 32'd1))
            new_request(c);
    endtask

    initial
    begin
        reset = 1'b1;
        fill = '0;
        out_almost_full = 1'b0;
        cyc = 0;
        timeouts = 0;
        drain_wait = 0;
        for (int c = 0; c < NUM_CHANNELS; c++)
        begin
            in_req[c] = '0;
            sent[c] = 0;
            waited[c] = 0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Fixed mappings first, entry 5 stays out until fill_at
        for (int k = 0; k < 5; k++)
        begin
            fill = mapping(k);
            @(negedge clk);
        end
        fill = '0;
        fill_at = 100 + int'(rand_bits(7));

        while ((timeouts == 0) && (cyc < RUN_LIMIT) && !stimulus_done())
        begin
            @(negedge clk);
            step_background();
            for (int c = 0; c < NUM_CHANNELS; c++)
                drive_channel(c);
        end
        if ((timeouts == 0) && !stimulus_done())
        begin
            timeouts++;
            $display("Timeout: stimulus did not finish within %0d cycles", RUN_LIMIT);
        end

        // Keep back-pressure going while the last requests drain
        while ((timeouts == 0) && (outstanding != 0))
        begin
            @(negedge clk);
            step_background();
            drain_wait++;
            if (drain_wait > DRAIN_LIMIT)
            begin
                timeouts++;
                $display("Timeout: %0d requests never left the DUT", outstanding);
            end
        end
        // A few idle cycles would show a late duplicate
        out_almost_full = 1'b0;
        repeat (10) @(negedge clk);

        $display("Closing: %0d checked, %0d value errors, %0d other errors, %0d timeouts",
                 checked, value_errors, other_errors, timeouts);
        if ((value_errors + other_errors + timeouts) == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: vtp_translate_top.f
hw/vtp_pkg.sv
hw/vtp_tlb.sv
hw/vtp_channel_pipe.sv
hw/vtp_out_arbiter.sv
hw/vtp_translate_top.sv
tb/vtp_translate_properties.sv
tb/vtp_translate_checker.sv
tb/vtp_translate_tb.sv

// File: run_sim.sh
#!/bin/bash
# Build the testbench with Verilator, run it and judge the log
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert \
    -f vtp_translate_top.f \
    --top-module vtp_translate_tb \
    -o vtp_sim
./obj_dir/vtp_sim | tee sim.log
if grep -q "SIMULATION PASSED" sim.log; then
    echo "run_sim: pass"
else
    echo "run_sim: fail"
    exit 1
fi
